// ==== build.f ====
+incdir+logic
logic/scr_ram_pkg.sv
logic/mem_port_if.sv
logic/addr_scrambler.sv
logic/keystream_gen.sv
logic/byte_diffuser.sv
logic/write_sched.sv
logic/sram_array.sv
logic/read_resp.sv
logic/scr_ram_top.sv
sim/tb_scr_ram.sv

// ==== logic/addr_scrambler.sv ====
// Keyed address substitution/permutation
`timescale 1ns/1ps
`include "scr_ram_macros.svh"

module addr_scrambler (
  input  scr_ram_pkg::addr_t addr_i,
  input  logic [7:0]         nonce_i,
  output scr_ram_pkg::addr_t addr_o
);

  //////////////////////////////////////////////////
  // Bijective address network
  //////////////////////////////////////////////////

  // Every round is a key add, a nibble S-box and a fixed wire permutation
  // Each of these steps is invertible on its own, so the whole map is a bijection
  // and no two raw addresses ever land on the same array row
  // The nonce byte selects which of the bijections is in use
  always_comb begin
    scr_ram_pkg::addr_t a;
    a = addr_i;
    for (int r = 0; r < `SCR_ADDR_ROUNDS; r++) begin
      // Key add with the top nonce byte
      a = a ^ nonce_i;
      // Substitution on both nibbles
      a = {scr_ram_pkg::sbox4(a[7:4]), scr_ram_pkg::sbox4(a[3:0])};
      // Spread the nibble bits over the whole address
      a = scr_ram_pkg::perm8(a);
    end
    addr_o = a;
  end

endmodule

// ==== logic/byte_diffuser.sv ====
// Byte-wise data diffusion
`timescale 1ns/1ps
`include "scr_ram_macros.svh"

module byte_diffuser #(
  parameter bit inverse_p = 1'b0
) (
  input  scr_ram_pkg::word_t data_i,
  output scr_ram_pkg::word_t data_o
);

  //////////////////////////////////////////////////
  // Per-byte substitution/permutation
  //////////////////////////////////////////////////

  // Flipping one stored bit disturbs the whole byte after descrambling
  // Diffusion never crosses a byte boundary, which keeps byte writes possible
  // The inverse runs the rounds in reverse, undoing the permutation first and then the S-box
  always_comb begin
    logic [7:0] b;
    data_o = '0;
    for (int k = 0; k < `SCR_BYTES; k++) begin
      b = data_i[8*k +: 8];
      for (int r = 0; r < `SCR_DIFF_ROUNDS; r++) begin
        if (!inverse_p) begin
          // Forward round on the write side
          b = {scr_ram_pkg::sbox4(b[7:4]), scr_ram_pkg::sbox4(b[3:0])};
          b = scr_ram_pkg::perm8(b);
        end else begin
          // Exact inverse round on the read side
          b = scr_ram_pkg::perm8_inv(b);
          b = {scr_ram_pkg::sbox4_inv(b[7:4]), scr_ram_pkg::sbox4_inv(b[3:0])};
        end
      end
      data_o[8*k +: 8] = b;
    end
  end

endmodule

// ==== logic/keystream_gen.sv ====
// Reduced-round keystream cipher
`timescale 1ns/1ps
`include "scr_ram_macros.svh"

module keystream_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   valid_i,
  input  logic [`SCR_KEY_W-1:0]  key_i,
  input  scr_ram_pkg::word_t     iv_i,
  output scr_ram_pkg::word_t     ks_o
);

  // One cipher round is a key add with alternating key halves and a round constant,
  // then nibble substitution and a bit spread where bit i moves to 8*i mod 31
  function automatic scr_ram_pkg::word_t ks_round(scr_ram_pkg::word_t s,
                                                  logic [`SCR_KEY_W-1:0] k, int r);
    scr_ram_pkg::word_t t;
    scr_ram_pkg::word_t p;
    t = s ^ k[32*(r % 2) +: 32] ^ {4{8'(r + 1)}};
    for (int n = 0; n < 8; n++) begin
      t[4*n +: 4] = scr_ram_pkg::sbox4(t[4*n +: 4]);
    end
    for (int i = 0; i < 31; i++) begin
      p[(8*i) % 31] = t[i];
    end
    p[31] = t[31];
    return p;
  endfunction

  //////////////////////////////////////////////////
  // First half and halfway register
  //////////////////////////////////////////////////

  scr_ram_pkg::word_t mid_d, mid_q;

  // The IV is the low nonce bits with the raw address, so every row gets its own stream
  always_comb begin
    mid_d = iv_i;
    for (int r = 0; r < `SCR_CIPHER_ROUNDS; r++) begin
      mid_d = ks_round(mid_d, key_i, r);
    end
  end

  // Loaded at grant, so the stream of a request is ready in the following cycle
  // The key stays static for as long as it is valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mid_q <= '0;
    end else if (valid_i) begin
      mid_q <= mid_d;
    end
  end

  //////////////////////////////////////////////////
  // Second half
  //////////////////////////////////////////////////

  // Round numbers carry on from the first half so the constants stay distinct
  always_comb begin
    scr_ram_pkg::word_t st;
    st = mid_q;
    for (int r = `SCR_CIPHER_ROUNDS; r < 2 * `SCR_CIPHER_ROUNDS; r++) begin
      st = ks_round(st, key_i, r);
    end
    // Final whitening with the low key half
    ks_o = st ^ key_i[31:0];
  end

endmodule

// ==== logic/mem_port_if.sv ====
// Scrambled array port
`timescale 1ns/1ps

interface mem_port_if;

  // Operation, scrambled address, scrambled word and byte enables for the array
  scr_ram_pkg::mem_op_e op;
  scr_ram_pkg::addr_t   addr;
  scr_ram_pkg::word_t   wdata;
  scr_ram_pkg::be_t     be;

  // Scrambled read word, valid the cycle after a MEM_READ
  scr_ram_pkg::word_t   rdata;

  // High in the cycle the read data of a read that hit a held write returns
  logic                 collide;

  modport sched (
    output op,
    output addr,
    output wdata,
    output be,
    output collide
  );

  modport array (
    input  op,
    input  addr,
    input  wdata,
    input  be,
    output rdata
  );

  modport resp (
    input  rdata,
    input  collide
  );

endinterface

// ==== logic/read_resp.sv ====
// Read response path
`timescale 1ns/1ps
`include "scr_ram_macros.svh"

module read_resp (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                read_en_i,
  input  logic                kill_i,
  input  scr_ram_pkg::word_t  ks_i,
  input  scr_ram_pkg::word_t  wdata_raw_i,
  input  scr_ram_pkg::be_t    be_raw_i,
  mem_port_if.resp            mem,
  output scr_ram_pkg::word_t  rdata_o,
  output logic                rvalid_o
);

  logic               rvalid_q;
  scr_ram_pkg::word_t rdata_xor, rdata_plain;

  // One response cycle per granted read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= read_en_i;
    end
  end

  //////////////////////////////////////////////////
  // Descrambling
  //////////////////////////////////////////////////

  // Undo diffusion first, the keystream XOR goes last to hide the cipher delay
  byte_diffuser #(
    .inverse_p (1'b1)
  ) u_diff_inv (
    .data_i (mem.rdata),
    .data_o (rdata_xor)
  );

  assign rdata_plain = rdata_xor ^ ks_i;

  // Killed responses return zeros with no valid
  // On a collision the enabled bytes come from the raw held write
  always_comb begin
    rdata_o  = '0;
    rvalid_o = 1'b0;
    if (rvalid_q && !kill_i) begin
      rvalid_o = 1'b1;
      for (int k = 0; k < `SCR_BYTES; k++) begin
        rdata_o[8*k +: 8] = (mem.collide && be_raw_i[k]) ? wdata_raw_i[8*k +: 8]
                                                          : rdata_plain[8*k +: 8];
      end
    end
  end

endmodule

// ==== logic/scr_ram_macros.svh ====
// Scrambled SRAM parameters
`ifndef SCR_RAM_MACROS_SVH
`define SCR_RAM_MACROS_SVH

// Data word and byte lane layout
`define SCR_DATA_W 32
`define SCR_BYTES 4

// The depth is 2**SCR_ADDR_W so the address map stays a bijection
`define SCR_ADDR_W 8
`define SCR_DEPTH 256

// Key material for the keystream cipher
`define SCR_KEY_W 64
`define SCR_NONCE_W 32

// Round counts of the three substitution/permutation networks
`define SCR_CIPHER_ROUNDS 2
`define SCR_DIFF_ROUNDS 2
`define SCR_ADDR_ROUNDS 2

`endif

// ==== logic/scr_ram_pkg.sv ====
// Scrambled SRAM types and primitives
`include "scr_ram_macros.svh"

package scr_ram_pkg;

  // Operation presented to the storage array in a given cycle
  typedef enum logic [1:0] {
    MEM_IDLE  = 2'b00,
    MEM_READ  = 2'b01,
    MEM_WRITE = 2'b10
  } mem_op_e;

  typedef logic [`SCR_DATA_W-1:0] word_t;
  typedef logic [`SCR_ADDR_W-1:0] addr_t;
  typedef logic [`SCR_BYTES-1:0]  be_t;

  // Entry i of the 4-bit S-box and of its inverse sits at bits 4*i+3:4*i
  localparam logic [63:0] SBOX4     = 64'h2174_8FE3_DA09_B65C;
  localparam logic [63:0] SBOX4_INV = 64'hA970_364B_D21C_8FE5;

  function automatic logic [3:0] sbox4(logic [3:0] x);
    return SBOX4[4*x +: 4];
  endfunction

  function automatic logic [3:0] sbox4_inv(logic [3:0] x);
    return SBOX4_INV[4*x +: 4];
  endfunction

  // Bit i moves to 2*i mod 7, the top bit stays where it is
  function automatic logic [7:0] perm8(logic [7:0] x);
    logic [7:0] y;
    for (int i = 0; i < 7; i++) begin
      y[(2*i) % 7] = x[i];
    end
    y[7] = x[7];
    return y;
  endfunction

  function automatic logic [7:0] perm8_inv(logic [7:0] x);
    logic [7:0] y;
    for (int i = 0; i < 7; i++) begin
      y[i] = x[(2*i) % 7];
    end
    y[7] = x[7];
    return y;
  endfunction

endpackage

// ==== logic/scr_ram_top.sv ====
// Scrambled single-port SRAM
`timescale 1ns/1ps
`include "scr_ram_macros.svh"

module scr_ram_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    key_valid_i,
  input  logic [`SCR_KEY_W-1:0]   key_i,
  input  logic [`SCR_NONCE_W-1:0] nonce_i,
  input  logic                    req_i,
  input  logic                    write_i,
  input  scr_ram_pkg::addr_t      addr_i,
  input  scr_ram_pkg::word_t      wdata_i,
  input  scr_ram_pkg::be_t        be_i,
  input  logic                    intg_error_i,
  output logic                    gnt_o,
  output scr_ram_pkg::word_t      rdata_o,
  output logic                    rvalid_o
);

  mem_port_if mem_if ();

  scr_ram_pkg::addr_t addr_scr;
  scr_ram_pkg::word_t ks, wdata_raw;
  scr_ram_pkg::be_t   be_raw;
  logic               read_en, kill;

  //////////////////////////////////////////////////
  // Address and keystream
  //////////////////////////////////////////////////

  // The top nonce byte keys the address map
  addr_scrambler u_addr_scr (
    .addr_i  (addr_i),
    .nonce_i (nonce_i[`SCR_NONCE_W-1 -: 8]),
    .addr_o  (addr_scr)
  );

  // Remaining nonce bits with the raw address form the counter-mode IV
  keystream_gen u_ks (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (gnt_o),
    .key_i   (key_i),
    .iv_i    ({nonce_i[`SCR_NONCE_W-9:0], addr_i}),
    .ks_o    (ks)
  );

  //////////////////////////////////////////////////
  // Request, storage and response
  //////////////////////////////////////////////////

  write_sched u_sched (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .key_valid_i  (key_valid_i),
    .req_i        (req_i),
    .write_i      (write_i),
    .intg_error_i (intg_error_i),
    .addr_scr_i   (addr_scr),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .ks_i         (ks),
    .gnt_o        (gnt_o),
    .read_en_o    (read_en),
    .kill_o       (kill),
    .wdata_raw_o  (wdata_raw),
    .be_raw_o     (be_raw),
    .mem          (mem_if.sched)
  );

  sram_array u_array (
    .clk_i (clk_i),
    .mem   (mem_if.array)
  );

  read_resp u_resp (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .read_en_i   (read_en),
    .kill_i      (kill),
    .ks_i        (ks),
    .wdata_raw_i (wdata_raw),
    .be_raw_i    (be_raw),
    .mem         (mem_if.resp),
    .rdata_o     (rdata_o),
    .rvalid_o    (rvalid_o)
  );

endmodule

// ==== logic/sram_array.sv ====
// Scrambled storage array
`timescale 1ns/1ps
`include "scr_ram_macros.svh"

module sram_array (
  input  logic       clk_i,
  mem_port_if.array  mem
);

  // Rows hold scrambled words at scrambled addresses only
  scr_ram_pkg::word_t mem_q [`SCR_DEPTH];
  scr_ram_pkg::word_t rdata_q;

  //////////////////////////////////////////////////
  // Single port access
  //////////////////////////////////////////////////

  // Diffusion is per byte, so a byte enable covers exactly one diffused lane
  always_ff @(posedge clk_i) begin
    if (mem.op == scr_ram_pkg::MEM_WRITE) begin
      for (int k = 0; k < `SCR_BYTES; k++) begin
        if (mem.be[k]) begin
          mem_q[mem.addr][8*k +: 8] <= mem.wdata[8*k +: 8];
        end
      end
    end
    // Read data appears in the next cycle and holds until the next read
    if (mem.op == scr_ram_pkg::MEM_READ) begin
      rdata_q <= mem_q[mem.addr];
    end
  end

  assign mem.rdata = rdata_q;

endmodule

// ==== logic/write_sched.sv ====
// Request side and write scheduling
`timescale 1ns/1ps

module write_sched (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                key_valid_i,
  input  logic                req_i,
  input  logic                write_i,
  input  logic                intg_error_i,
  input  scr_ram_pkg::addr_t  addr_scr_i,
  input  scr_ram_pkg::word_t  wdata_i,
  input  scr_ram_pkg::be_t    be_i,
  input  scr_ram_pkg::word_t  ks_i,
  output logic                gnt_o,
  output logic                read_en_o,
  output logic                kill_o,
  output scr_ram_pkg::word_t  wdata_raw_o,
  output scr_ram_pkg::be_t    be_raw_o,
  mem_port_if.sched           mem
);

  //////////////////////////////////////////////////
  // Grant and strobes
  //////////////////////////////////////////////////

  logic rd_en, wr_load, wr_q, pend_q, pend_d, wr_go;
  logic collide_d, collide_q, kill_q;

  assign gnt_o     = req_i & key_valid_i;
  assign rd_en     = gnt_o & ~write_i;
  assign read_en_o = rd_en;

  // A write granted together with an integrity error is dropped right here
  // so it never reaches the holding registers and can never be forwarded
  assign wr_load = gnt_o & write_i & ~intg_error_i;

  // The delayed or pending write may use the array only in a cycle without a read,
  // and the error input silences the array for the current cycle
  assign wr_go = (wr_q | pend_q) & ~rd_en & ~intg_error_i;

  // A delayed write that cannot go now is parked, and the flag clears once it drains
  assign pend_d = wr_go ? 1'b0 : (wr_q ? 1'b1 : pend_q);

  // A read that hits the held write row is forwarded from the raw holding register
  scr_ram_pkg::addr_t waddr_q;
  assign collide_d = rd_en & (wr_q | pend_q) & (addr_scr_i == waddr_q);

  //////////////////////////////////////////////////
  // Write data scrambling
  //////////////////////////////////////////////////

  scr_ram_pkg::word_t wdata_q, wdata_xor, wdata_diff, wdata_scr_q;
  scr_ram_pkg::be_t   be_q;

  // Keystream first, then diffusion, so the read path can strip the keystream last
  assign wdata_xor = wdata_q ^ ks_i;

  byte_diffuser #(
    .inverse_p (1'b0)
  ) u_diff_fwd (
    .data_i (wdata_xor),
    .data_o (wdata_diff)
  );

  //////////////////////////////////////////////////
  // Array request
  //////////////////////////////////////////////////

  always_comb begin
    mem.op = scr_ram_pkg::MEM_IDLE;
    if (rd_en && !intg_error_i) begin
      mem.op = scr_ram_pkg::MEM_READ;
    end else if (wr_go) begin
      mem.op = scr_ram_pkg::MEM_WRITE;
    end
  end

  // A parked write reuses its saved word since the keystream has moved on
  assign mem.addr    = rd_en ? addr_scr_i : waddr_q;
  assign mem.wdata   = pend_q ? wdata_scr_q : wdata_diff;
  assign mem.be      = be_q;
  assign mem.collide = collide_q;

  assign wdata_raw_o = wdata_q;
  assign be_raw_o    = be_q;
  assign kill_o      = kill_q;

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_q      <= 1'b0;
      pend_q    <= 1'b0;
      collide_q <= 1'b0;
      kill_q    <= 1'b0;
    end else begin
      wr_q      <= wr_load;
      pend_q    <= pend_d;
      collide_q <= collide_d;
      kill_q    <= intg_error_i;
    end
  end

  // The raw copy of the write payload also serves collision forwarding
  always_ff @(posedge clk_i) begin
    if (wr_load) begin
      waddr_q <= addr_scr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
    // Capture the scrambled word while its keystream is still on ks_i
    if (wr_q && !wr_go) begin
      wdata_scr_q <= wdata_diff;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the scrambled SRAM testbench with Verilator and runs it
# The run passes only when the simulation prints the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_scr_ram -f build.f \
  && { out="$(./obj_dir/Vtb_scr_ram)"; echo "$out"; echo "$out" | grep -qx "TEST PASS"; } \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== sim/tb_scr_ram.sv ====
// Scrambled SRAM testbench
`timescale 1ns/1ps
`include "scr_ram_macros.svh"

module tb_scr_ram;

  // Directed and random traffic stay inside a small window of rows
  localparam int WINDOW          = 16;
  localparam int RAND_OPS        = 300;
  localparam int RESET_CYCLES    = 5;
  // Bound on directed cycles apart from the window fill and the final readback
  localparam int DIRECTED_CYCLES = 64;
  localparam int STIM_CYCLES     = RESET_CYCLES + 2 * WINDOW + DIRECTED_CYCLES + RAND_OPS;
  localparam int TIMEOUT_CYCLES  = 4 * STIM_CYCLES + 100;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    key_valid_i;
  logic [`SCR_KEY_W-1:0]   key_i;
  logic [`SCR_NONCE_W-1:0] nonce_i;
  logic                    req_i;
  logic                    write_i;
  scr_ram_pkg::addr_t      addr_i;
  scr_ram_pkg::word_t      wdata_i;
  scr_ram_pkg::be_t        be_i;
  logic                    intg_error_i;
  logic                    gnt_o;
  scr_ram_pkg::word_t      rdata_o;
  logic                    rvalid_o;

  int seed;
  int errors;
  int n_reads;
  int n_writes;
  int wait_cycles;

  // The reference image is indexed by the raw address
  scr_ram_pkg::word_t ref_mem [`SCR_DEPTH];
  logic               exp_rvalid;
  scr_ram_pkg::word_t exp_rdata;

  scr_ram_top uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .key_valid_i  (key_valid_i),
    .key_i        (key_i),
    .nonce_i      (nonce_i),
    .req_i        (req_i),
    .write_i      (write_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .intg_error_i (intg_error_i),
    .gnt_o        (gnt_o),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o)
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // A request is granted only while the key is valid
  // Writes land in the image at grant, so a read right behind a write sees merged bytes
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      exp_rvalid <= 1'b0;
      exp_rdata  <= '0;
    end else begin
      exp_rvalid <= req_i && key_valid_i && !write_i && !intg_error_i;
      if (req_i && key_valid_i && !intg_error_i) begin
        if (write_i) begin
          for (int k = 0; k < `SCR_BYTES; k++) begin
            if (be_i[k]) begin
              ref_mem[addr_i][8*k +: 8] = wdata_i[8*k +: 8];
            end
          end
        end else begin
          exp_rdata <= ref_mem[addr_i];
        end
      end
    end
  end

  // Grant is a pure combination of request and key state
  check_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_o == (req_i && key_valid_i))
    else begin
      errors = errors + 1;
      $display("MISMATCH at %0t: gnt_o=%0b for req_i=%0b key_valid_i=%0b", $time,
               $sampled(gnt_o), $sampled(req_i), $sampled(key_valid_i));
    end

  // Exactly one response cycle per clean granted read, and none otherwise
  check_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o == exp_rvalid)
    else begin
      errors = errors + 1;
      $display("MISMATCH at %0t: rvalid_o=%0b expected %0b", $time,
               $sampled(rvalid_o), $sampled(exp_rvalid));
    end

  check_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> rdata_o == exp_rdata)
    else begin
      errors = errors + 1;
      $display("MISMATCH at %0t: rdata_o=%08h expected %08h", $time,
               $sampled(rdata_o), $sampled(exp_rdata));
    end

  // Killed and idle cycles show a zero data bus
  check_rdata_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rvalid_o |-> rdata_o == '0)
    else begin
      errors = errors + 1;
      $display("MISMATCH at %0t: rdata_o=%08h while rvalid_o is low", $time,
               $sampled(rdata_o));
    end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Every bit of the address shows up somewhere in the word
  function automatic scr_ram_pkg::word_t fill_pattern(scr_ram_pkg::addr_t a);
    return {a ^ 8'h3c, ~a, a + 8'h17, {a[3:0], a[7:4]}};
  endfunction

  task automatic write_word(input scr_ram_pkg::addr_t a, input scr_ram_pkg::word_t d,
                            input scr_ram_pkg::be_t b, input logic err);
    @(posedge clk_i);
    req_i        <= 1'b1;
    write_i      <= 1'b1;
    addr_i       <= a;
    wdata_i      <= d;
    be_i         <= b;
    intg_error_i <= err;
    n_writes = n_writes + 1;
  endtask

  task automatic read_word(input scr_ram_pkg::addr_t a, input logic err);
    @(posedge clk_i);
    req_i        <= 1'b1;
    write_i      <= 1'b0;
    addr_i       <= a;
    intg_error_i <= err;
    n_reads = n_reads + 1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      req_i        <= 1'b0;
      write_i      <= 1'b0;
      intg_error_i <= 1'b0;
    end
  endtask

  // Mixed reads, writes and gaps inside the window, back to back most of the time
  task automatic random_traffic(input int n);
    int                 rnd;
    scr_ram_pkg::addr_t a;
    scr_ram_pkg::word_t d;
    for (int i = 0; i < n; i++) begin
      rnd = $random(seed);
      a   = {4'h0, rnd[3:0]};
      d   = $random(seed);
      if (rnd[11:9] == 3'd0) begin
        idle_cycles(1);
      end else if (rnd[8]) begin
        write_word(a, d, rnd[7:4], 1'b0);
      end else begin
        read_word(a, 1'b0);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    key_valid_i  = 1'b1;
    key_i        = 64'h3c9a_71e4_0f5b_d826;
    nonce_i      = 32'h9e37_79b9;
    req_i        = 1'b0;
    write_i      = 1'b0;
    addr_i       = '0;
    wdata_i      = '0;
    be_i         = '0;
    intg_error_i = 1'b0;
    seed         = 32'h0adf_05bd;
    errors       = 0;
    n_reads      = 0;
    n_writes     = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Fill the window with full words, each write drains the one before it
    for (int i = 0; i < WINDOW; i++) begin
      write_word(scr_ram_pkg::addr_t'(i), fill_pattern(scr_ram_pkg::addr_t'(i)), 4'hf, 1'b0);
    end
    idle_cycles(2);

    // No grant without a key, so neither writes nor reads take effect
    idle_cycles(1);
    key_valid_i <= 1'b0;
    for (int i = 0; i < 4; i++) begin
      write_word(scr_ram_pkg::addr_t'(i), 32'hffff_0000, 4'hf, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      read_word(scr_ram_pkg::addr_t'(i), 1'b0);
    end
    idle_cycles(1);
    key_valid_i <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      read_word(scr_ram_pkg::addr_t'(i), 1'b0);
    end
    idle_cycles(2);

    // Sparse byte enables keep the old bytes where the enable is low
    write_word(8'd4, 32'h1111_1111, 4'b0101, 1'b0);
    write_word(8'd5, 32'h2222_2222, 4'b1010, 1'b0);
    write_word(8'd6, 32'h3333_3333, 4'b0001, 1'b0);
    write_word(8'd7, 32'h4444_4444, 4'b1000, 1'b0);
    idle_cycles(2);
    for (int i = 4; i < 8; i++) begin
      read_word(scr_ram_pkg::addr_t'(i), 1'b0);
    end
    idle_cycles(2);

    // Read right behind a write to the same row
    write_word(8'd8, 32'hdead_beef, 4'b0110, 1'b0);
    read_word(8'd8, 1'b0);
    idle_cycles(1);
    // Write, read, write where the parked word still goes out first
    write_word(8'd9, 32'h1234_5678, 4'hf, 1'b0);
    read_word(8'd9, 1'b0);
    write_word(8'd8, 32'h0bad_cafe, 4'b1001, 1'b0);
    idle_cycles(1);
    // Write, read, read, write with the second read hitting the pending write
    write_word(8'd10, 32'h5a5a_a5a5, 4'b0011, 1'b0);
    read_word(8'd11, 1'b0);
    read_word(8'd10, 1'b0);
    write_word(8'd11, 32'h7788_99aa, 4'b1100, 1'b0);
    idle_cycles(2);
    for (int i = 8; i < 12; i++) begin
      read_word(scr_ram_pkg::addr_t'(i), 1'b0);
    end
    idle_cycles(2);

    // Integrity errors kill the response and drop the write
    idle_cycles(1);
    read_word(8'd12, 1'b1);
    idle_cycles(1);
    write_word(8'd12, 32'hbad0_bad0, 4'hf, 1'b1);
    idle_cycles(2);
    read_word(8'd12, 1'b0);
    idle_cycles(2);

    random_traffic(RAND_OPS);

    // Read the whole window back once more
    for (int i = 0; i < WINDOW; i++) begin
      read_word(scr_ram_pkg::addr_t'(i), 1'b0);
    end
    idle_cycles(3);

    $display("Summary: %0d reads, %0d writes issued, %0d errors", n_reads, n_writes, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog in case the sequence stalls
  initial begin
    wait_cycles = 0;
    while (wait_cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      wait_cycles = wait_cycles + 1;
    end
    $display("Timeout: the test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule
